// ==== Makefile ====
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= pipe_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The simulator status is not trusted, the log decides
run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Test passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/decode_stage.sv ====
// Decode stage with fetch latch, operand forwarding muxes and the decode/execute register
module decode_stage (
    input  logic                clk_i,
    input  logic                rst_i,
    input  pipe_pkg::instr_t    instr_i,
    input  logic                instr_valid_i,
    input  logic                stall_i,
    input  logic                flush_i,
    input  pipe_pkg::xlen_t     rdata1_i,
    input  pipe_pkg::xlen_t     rdata2_i,
    input  pipe_pkg::fwd_sel_e  fwd_sel1_i,
    input  pipe_pkg::fwd_sel_e  fwd_sel2_i,
    stage_result_if.sink        ex_res,
    stage_result_if.sink        wb_res,
    output pipe_pkg::reg_addr_t rs1_o,
    output pipe_pkg::reg_addr_t rs2_o,
    output pipe_pkg::xlen_t     op_a_o,
    output pipe_pkg::xlen_t     op_b_o,
    output pipe_pkg::alu_op_e   alu_op_o,
    output pipe_pkg::reg_addr_t rd_o,
    output logic                wr_en_o,
    output logic                valid_o
);

    pipe_pkg::instr_t  instr_q;
    logic              instr_vld_q;
    pipe_pkg::alu_op_e dec_op;
    pipe_pkg::xlen_t   imm;
    logic              use_imm;
    pipe_pkg::xlen_t   src1;
    pipe_pkg::xlen_t   src2;

    // Fetch latch
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            instr_vld_q <= 1'b0;
        end else if (!stall_i) begin
            instr_vld_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            instr_q <= instr_i;
        end
    end

    assign rs1_o = instr_q[19:15];
    assign rs2_o = instr_q[24:20];
    assign imm   = {{20{instr_q[31]}}, instr_q[31:20]}; // I-type, sign extended

    always_comb begin
        dec_op  = pipe_pkg::ALU_NONE;
        use_imm = 1'b0;
        if (instr_q[6:0] == pipe_pkg::OPC_OP) begin
            if (instr_q[31:25] == pipe_pkg::F7_BASE) begin
                case (instr_q[14:12])
                    pipe_pkg::F3_ADD: dec_op = pipe_pkg::ALU_ADD;
                    pipe_pkg::F3_XOR: dec_op = pipe_pkg::ALU_XOR;
                    pipe_pkg::F3_OR:  dec_op = pipe_pkg::ALU_OR;
                    pipe_pkg::F3_AND: dec_op = pipe_pkg::ALU_AND;
                    default:          dec_op = pipe_pkg::ALU_NONE;
                endcase
            end else if (instr_q[14:12] == pipe_pkg::F3_ADD) begin
                if (instr_q[31:25] == pipe_pkg::F7_SUB) dec_op = pipe_pkg::ALU_SUB;
                if (instr_q[31:25] == pipe_pkg::F7_MUL) dec_op = pipe_pkg::ALU_MUL;
            end
        end else if (instr_q[6:0] == pipe_pkg::OPC_OP_IMM
                     && instr_q[14:12] == pipe_pkg::F3_ADD) begin
            dec_op  = pipe_pkg::ALU_ADD; // ADDI
            use_imm = 1'b1;
        end
    end

    // Operand sources
    always_comb begin
        case (fwd_sel1_i)
            pipe_pkg::FWD_EX: src1 = ex_res.data;
            pipe_pkg::FWD_WB: src1 = wb_res.data;
            default:          src1 = rdata1_i;
        endcase
        case (fwd_sel2_i)
            pipe_pkg::FWD_EX: src2 = ex_res.data;
            pipe_pkg::FWD_WB: src2 = wb_res.data;
            default:          src2 = rdata2_i;
        endcase
    end

    // Decode/execute register, bubble on stall or flush
    always_ff @(posedge clk_i) begin
        if (rst_i || stall_i || flush_i) begin
            valid_o <= 1'b0;
            wr_en_o <= 1'b0;
        end else begin
            valid_o <= instr_vld_q;
            wr_en_o <= instr_vld_q && (dec_op != pipe_pkg::ALU_NONE);
        end
    end

    always_ff @(posedge clk_i) begin
        op_a_o   <= src1;
        op_b_o   <= use_imm ? imm : src2;
        alu_op_o <= dec_op;
        rd_o     <= instr_q[11:7];
    end

endmodule

// ==== hdl/execute_stage.sv ====
// Execute stage with ALU, iterative shift-add multiplier and the execute/writeback register
module execute_stage (
    input  logic                clk_i,
    input  logic                rst_i,
    input  pipe_pkg::xlen_t     op_a_i,
    input  pipe_pkg::xlen_t     op_b_i,
    input  pipe_pkg::alu_op_e   alu_op_i,
    input  pipe_pkg::reg_addr_t rd_i,
    input  logic                wr_en_i,
    input  logic                valid_i,
    output logic                ex_ready_o,
    stage_result_if.source      ex_res,
    stage_result_if.source      wb_res
);

    logic                                   mul_busy_q;
    logic [$clog2(pipe_pkg::MUL_CYCLES)-1:0] mul_cnt_q;
    logic                                   mul_wr_q;
    pipe_pkg::reg_addr_t                    mul_rd_q;
    pipe_pkg::xlen_t                        mul_acc_q;
    pipe_pkg::xlen_t                        mul_mcand_q;
    pipe_pkg::xlen_t                        mul_mplier_q;

    logic            mul_start;
    logic            mul_last;
    pipe_pkg::xlen_t cur_acc;
    pipe_pkg::xlen_t cur_mcand;
    pipe_pkg::xlen_t cur_mplier;
    pipe_pkg::xlen_t mul_part;
    pipe_pkg::xlen_t acc_next;
    pipe_pkg::xlen_t alu_res;

    assign mul_start = valid_i && !mul_busy_q && (alu_op_i == pipe_pkg::ALU_MUL);
    assign mul_last  = mul_busy_q && (mul_cnt_q == pipe_pkg::MUL_CYCLES - 1);

    // First step runs straight from the operands
    assign cur_acc    = mul_busy_q ? mul_acc_q    : '0;
    assign cur_mcand  = mul_busy_q ? mul_mcand_q  : op_a_i;
    assign cur_mplier = mul_busy_q ? mul_mplier_q : op_b_i;

    // One nibble of the multiplier per cycle, low 32 bits kept
    always_comb begin
        mul_part = '0;
        for (int i = 0; i < 4; i++) begin
            if (cur_mplier[i]) begin
                mul_part = mul_part + (cur_mcand << i);
            end
        end
    end

    assign acc_next = cur_acc + mul_part;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mul_busy_q <= 1'b0;
            mul_cnt_q  <= '0;
        end else if (mul_start) begin
            mul_busy_q <= 1'b1;
            mul_cnt_q  <= 1;
        end else if (mul_busy_q) begin
            mul_busy_q <= !mul_last;
            mul_cnt_q  <= mul_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mul_start) begin
            mul_wr_q <= wr_en_i;
            mul_rd_q <= rd_i;
        end
        mul_acc_q    <= acc_next;
        mul_mcand_q  <= cur_mcand << 4;
        mul_mplier_q <= cur_mplier >> 4;
    end

    always_comb begin
        case (alu_op_i)
            pipe_pkg::ALU_ADD: alu_res = op_a_i + op_b_i;
            pipe_pkg::ALU_SUB: alu_res = op_a_i - op_b_i;
            pipe_pkg::ALU_AND: alu_res = op_a_i & op_b_i;
            pipe_pkg::ALU_OR:  alu_res = op_a_i | op_b_i;
            pipe_pkg::ALU_XOR: alu_res = op_a_i ^ op_b_i;
            pipe_pkg::ALU_MUL: alu_res = acc_next;
            default:           alu_res = '0;
        endcase
    end

    // Held low until the last multiply step
    assign ex_ready_o = !(mul_start || (mul_busy_q && !mul_last));

    always_comb begin
        if (mul_busy_q) begin
            ex_res.wr_en      = mul_wr_q;
            ex_res.rd         = mul_rd_q;
            ex_res.data       = acc_next;
            ex_res.data_valid = mul_last;
        end else begin
            ex_res.wr_en      = valid_i && wr_en_i;
            ex_res.rd         = rd_i;
            ex_res.data       = alu_res;
            ex_res.data_valid = (alu_op_i != pipe_pkg::ALU_MUL);
        end
    end

    // Execute/writeback register, only finished writes to rd other than x0
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_res.wr_en      <= 1'b0;
            wb_res.data_valid <= 1'b0;
        end else begin
            wb_res.wr_en      <= ex_res.wr_en && ex_res.data_valid && (ex_res.rd != '0);
            wb_res.data_valid <= ex_res.data_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_res.rd   <= ex_res.rd;
        wb_res.data <= ex_res.data;
    end

endmodule

// ==== hdl/hazard_ctrl.sv ====
// Hazard unit with operand forwarding, stall and flush control and per-stage invalid flags
module hazard_ctrl (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                mispredict_i,
    input  logic                fetch_ready_i,
    input  logic                ex_ready_i,
    input  pipe_pkg::reg_addr_t rs1_i,
    input  pipe_pkg::reg_addr_t rs2_i,
    stage_result_if.sink        ex_res,
    stage_result_if.sink        wb_res,
    output pipe_pkg::fwd_sel_e  fwd_sel1_o,
    output pipe_pkg::fwd_sel_e  fwd_sel2_o,
    output logic                stall_o,
    output logic                flush_o
);

    logic [3:0] invalid_q;
    logic       first_q;  // First cycle out of reset
    logic       ex_hit1;
    logic       ex_hit2;
    logic       wb_hit1;
    logic       wb_hit2;

    // An invalid execute slot may still forward once its data is final
    assign ex_hit1 = ex_res.wr_en && (ex_res.rd == rs1_i) && (rs1_i != '0)
                     && (!invalid_q[pipe_pkg::STAGE_EXEC] || ex_res.data_valid);
    assign ex_hit2 = ex_res.wr_en && (ex_res.rd == rs2_i) && (rs2_i != '0)
                     && (!invalid_q[pipe_pkg::STAGE_EXEC] || ex_res.data_valid);

    assign wb_hit1 = wb_res.wr_en && (wb_res.rd == rs1_i) && (rs1_i != '0)
                     && !invalid_q[pipe_pkg::STAGE_WB];
    assign wb_hit2 = wb_res.wr_en && (wb_res.rd == rs2_i) && (rs2_i != '0)
                     && !invalid_q[pipe_pkg::STAGE_WB];

    // Execute is the younger result and wins
    assign fwd_sel1_o = ex_hit1 ? pipe_pkg::FWD_EX :
                        wb_hit1 ? pipe_pkg::FWD_WB : pipe_pkg::FWD_NONE;
    assign fwd_sel2_o = ex_hit2 ? pipe_pkg::FWD_EX :
                        wb_hit2 ? pipe_pkg::FWD_WB : pipe_pkg::FWD_NONE;

    // Multiplier busy, or decode needs a result that is not ready yet
    assign stall_o = !ex_ready_i || (!ex_res.data_valid && (ex_hit1 || ex_hit2));

    assign flush_o = first_q || mispredict_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            invalid_q <= 4'b1111;
            first_q   <= 1'b1;
        end else begin
            first_q                         <= 1'b0;
            invalid_q[pipe_pkg::STAGE_FETCH] <= 1'b0;

            // Fetch latch contents; an empty fetch slot becomes a bubble
            if (flush_o) begin
                invalid_q[pipe_pkg::STAGE_DECODE] <= 1'b1;
            end else if (!stall_o) begin
                invalid_q[pipe_pkg::STAGE_DECODE] <= invalid_q[pipe_pkg::STAGE_FETCH]
                                                     || !fetch_ready_i;
            end

            // Multiplier keeps its own slot while busy
            if (ex_ready_i) begin
                invalid_q[pipe_pkg::STAGE_EXEC] <= mispredict_i || stall_o
                                                   || invalid_q[pipe_pkg::STAGE_DECODE];
            end

            invalid_q[pipe_pkg::STAGE_WB] <= invalid_q[pipe_pkg::STAGE_EXEC];
        end
    end

endmodule

// ==== hdl/pipe_pkg.sv ====
// Pipeline package with shared widths, opcodes, ALU operations and forwarding selects
package pipe_pkg;

    typedef logic [31:0] xlen_t;     // Data word
    typedef logic [4:0]  reg_addr_t; // Register index
    typedef logic [31:0] instr_t;    // Raw instruction

    // Major opcodes handled by decode
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 and funct7 fields of the supported subset
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;
    localparam logic [6:0] F7_MUL  = 7'b0000001;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_MUL,
        ALU_NONE // Unsupported encoding, retires as a bubble
    } alu_op_e;

    // Operand source picked in decode
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_EX   = 2'b01,
        FWD_WB   = 2'b10
    } fwd_sel_e;

    // 4 bits of multiplier per cycle
    localparam int MUL_CYCLES = 8;

    // Bit positions in the invalid vector of the hazard unit
    localparam int STAGE_FETCH  = 0;
    localparam int STAGE_DECODE = 1;
    localparam int STAGE_EXEC   = 2;
    localparam int STAGE_WB     = 3;

endpackage

// ==== hdl/pipe_top.sv ====
// Pipeline top level joining decode, execute, register file and hazard unit
module pipe_top (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [31:0] instr_i,
    input  logic        instr_valid_i,
    input  logic        mispredict_i,
    output logic        stall_o,
    output logic        wb_valid_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_data_o
);

    stage_result_if ex_res ();
    stage_result_if wb_res ();

    pipe_pkg::reg_addr_t rs1;
    pipe_pkg::reg_addr_t rs2;
    pipe_pkg::xlen_t     rdata1;
    pipe_pkg::xlen_t     rdata2;
    pipe_pkg::fwd_sel_e  fwd_sel1;
    pipe_pkg::fwd_sel_e  fwd_sel2;
    logic                stall;
    logic                flush;
    pipe_pkg::xlen_t     op_a;
    pipe_pkg::xlen_t     op_b;
    pipe_pkg::alu_op_e   alu_op;
    pipe_pkg::reg_addr_t rd;
    logic                wr_en;
    logic                valid;
    logic                ex_ready;

    hazard_ctrl u_hazard (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .mispredict_i (mispredict_i),
        .fetch_ready_i(instr_valid_i),
        .ex_ready_i   (ex_ready),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .ex_res       (ex_res),
        .wb_res       (wb_res),
        .fwd_sel1_o   (fwd_sel1),
        .fwd_sel2_o   (fwd_sel2),
        .stall_o      (stall),
        .flush_o      (flush)
    );

    reg_file u_rf (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .rdata1_o(rdata1),
        .rdata2_o(rdata2),
        .wb_res  (wb_res)
    );

    decode_stage u_dec (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .instr_i      (instr_i),
        .instr_valid_i(instr_valid_i),
        .stall_i      (stall),
        .flush_i      (flush),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .fwd_sel1_i   (fwd_sel1),
        .fwd_sel2_i   (fwd_sel2),
        .ex_res       (ex_res),
        .wb_res       (wb_res),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .op_a_o       (op_a),
        .op_b_o       (op_b),
        .alu_op_o     (alu_op),
        .rd_o         (rd),
        .wr_en_o      (wr_en),
        .valid_o      (valid)
    );

    execute_stage u_ex (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .op_a_i    (op_a),
        .op_b_i    (op_b),
        .alu_op_i  (alu_op),
        .rd_i      (rd),
        .wr_en_i   (wr_en),
        .valid_i   (valid),
        .ex_ready_o(ex_ready),
        .ex_res    (ex_res),
        .wb_res    (wb_res)
    );

    assign stall_o    = stall;
    assign wb_valid_o = wb_res.wr_en; // One pulse per retiring write
    assign wb_rd_o    = wb_res.rd;
    assign wb_data_o  = wb_res.data;

endmodule

// ==== hdl/reg_file.sv ====
// Register file with 32 words, two combinational read ports and one write port
module reg_file (
    input  logic                clk_i,
    input  logic                rst_i,
    input  pipe_pkg::reg_addr_t rs1_i,
    input  pipe_pkg::reg_addr_t rs2_i,
    output pipe_pkg::xlen_t     rdata1_o,
    output pipe_pkg::xlen_t     rdata2_o,
    stage_result_if.sink        wb_res
);

    pipe_pkg::xlen_t regs [32];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_res.wr_en && wb_res.data_valid && (wb_res.rd != '0)) begin
            regs[wb_res.rd] <= wb_res.data;
        end
    end

    // x0 reads as zero
    assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// ==== hdl/stage_result_if.sv ====
// Destination write information of one stage, used for forwarding and hazard checks
interface stage_result_if;

    logic                wr_en;      // Stage will write rd
    pipe_pkg::reg_addr_t rd;
    pipe_pkg::xlen_t     data;
    logic                data_valid; // Low while the result is still pending

    modport source (
        output wr_en,
        output rd,
        output data,
        output data_valid
    );

    modport sink (
        input wr_en,
        input rd,
        input data,
        input data_valid
    );

endinterface

// ==== tb.f ====
hdl/pipe_pkg.sv
hdl/stage_result_if.sv
hdl/hazard_ctrl.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/pipe_top.sv
verif/pipe_tb.sv

// ==== verif/pipe_tb.sv ====
// Testbench for the pipeline slice, table-driven stimulus checked against a register model
module pipe_tb;

    localparam int STALL_LIMIT = 50;  // Cycles an entry may be held
    localparam int DRAIN_LIMIT = 100;

    // funct7 and funct3 joined, for R-type encodings
    localparam logic [9:0] FN_ADD = 10'b0000000_000;
    localparam logic [9:0] FN_SUB = 10'b0100000_000;
    localparam logic [9:0] FN_AND = 10'b0000000_111;
    localparam logic [9:0] FN_OR  = 10'b0000000_110;
    localparam logic [9:0] FN_XOR = 10'b0000000_100;
    localparam logic [9:0] FN_MUL = 10'b0000001_000;
    localparam logic [9:0] FN_SLT = 10'b0000000_010; // Not supported by the DUT

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic        instr_valid;
    logic        mispredict;
    logic        stall;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] tbl_instr[$];
    bit          tbl_mispredict[$];
    bit          tbl_squash[$];

    logic [31:0] arch_regs [32];
    logic [4:0]  exp_rd_q[$];
    logic [31:0] exp_data_q[$];
    logic        stall_seen;
    int          retired;
    int          gap;
    int          waited;

    pipe_top uut (
        .clk_i        (clk),
        .rst_i        (rst),
        .instr_i      (instr),
        .instr_valid_i(instr_valid),
        .mispredict_i (mispredict),
        .stall_o      (stall),
        .wb_valid_o   (wb_valid),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERR time=%0t signal=%s got=0x%08h expected=0x%08h",
                                $time, name, actual, expected));
        end
    endtask

    function automatic logic [31:0] r_word(input logic [9:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {fn[9:3], rs2, rs1, fn[2:0], rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    task automatic add_entry(input logic [31:0] word, input bit mis, input bit squash);
        tbl_instr.push_back(word);
        tbl_mispredict.push_back(mis);
        tbl_squash.push_back(squash);
    endtask

    task automatic build_table();
        // Dependent chain through both forwarding paths
        add_entry(addi_word(5'd1, 5'd0, 12'd5), 0, 0);
        add_entry(r_word(FN_ADD, 5'd2, 5'd1, 5'd1), 0, 0);
        add_entry(r_word(FN_SUB, 5'd3, 5'd2, 5'd1), 0, 0);
        add_entry(r_word(FN_XOR, 5'd4, 5'd3, 5'd2), 0, 0);
        add_entry(addi_word(5'd5, 5'd1, 12'hED4), 0, 0);   // Immediate of -300
        add_entry(r_word(FN_OR, 5'd6, 5'd4, 5'd5), 0, 0);
        add_entry(r_word(FN_AND, 5'd7, 5'd6, 5'd2), 0, 0);
        // Writes to x0 and an unsupported encoding
        add_entry(addi_word(5'd0, 5'd1, 12'd77), 0, 0);
        add_entry(r_word(FN_ADD, 5'd8, 5'd0, 5'd1), 0, 0);
        add_entry(r_word(FN_SLT, 5'd9, 5'd1, 5'd2), 0, 0);
        add_entry(r_word(FN_ADD, 5'd10, 5'd9, 5'd1), 0, 0);
        // Multiplier with dependent followers
        add_entry(addi_word(5'd13, 5'd0, 12'd1234), 0, 0);
        add_entry(r_word(FN_MUL, 5'd12, 5'd5, 5'd13), 0, 0);
        add_entry(r_word(FN_ADD, 5'd14, 5'd12, 5'd13), 0, 0);
        add_entry(r_word(FN_MUL, 5'd15, 5'd14, 5'd14), 0, 0); // Product wraps past 32 bits
        add_entry(r_word(FN_SUB, 5'd16, 5'd15, 5'd12), 0, 0);
        add_entry(r_word(FN_XOR, 5'd17, 5'd15, 5'd14), 0, 0);
        // Latched entry and the one presented with the mispredict are both dropped
        add_entry(addi_word(5'd18, 5'd0, 12'd100), 0, 0);
        add_entry(addi_word(5'd19, 5'd0, 12'd200), 0, 0);
        add_entry(addi_word(5'd18, 5'd18, 12'd1), 0, 1);
        add_entry(addi_word(5'd19, 5'd19, 12'd1), 1, 1);
        add_entry(r_word(FN_ADD, 5'd20, 5'd18, 5'd19), 0, 0);
        add_entry(r_word(FN_ADD, 5'd21, 5'd20, 5'd17), 0, 0);
    endtask

    // Architectural effect of one retired instruction
    task automatic model_apply(input logic [31:0] word);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic        writes;
        rd     = word[11:7];
        a      = arch_regs[word[19:15]];
        b      = arch_regs[word[24:20]];
        imm    = {{20{word[31]}}, word[31:20]};
        res    = '0;
        writes = 1'b1;
        if (word[6:0] == 7'b0110011) begin
            case ({word[31:25], word[14:12]})
                FN_ADD:  res = a + b;
                FN_SUB:  res = a - b;
                FN_AND:  res = a & b;
                FN_OR:   res = a | b;
                FN_XOR:  res = a ^ b;
                FN_MUL:  res = a * b;  // Low word only
                default: writes = 1'b0;
            endcase
        end else if (word[6:0] == 7'b0010011 && word[14:12] == 3'b000) begin
            res = a + imm;
        end else begin
            writes = 1'b0;
        end
        if (writes && rd != 5'd0) begin
            arch_regs[rd] = res;
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
        end
    endtask

    // Returns at the edge that takes the instruction
    task automatic wait_accept();
        int held;
        held = 0;
        @(negedge clk);
        while (stall !== 1'b0) begin
            stall_seen = 1'b1;
            held++;
            if (held > STALL_LIMIT) begin
                abort_run("Instruction was held by stall_o for too long");
            end
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // Writeback monitor
    always @(negedge clk) begin
        if (!rst && wb_valid === 1'b1) begin
            if (exp_rd_q.size() == 0) begin
                abort_run($sformatf("Unexpected writeback to x%0d at time %0t", wb_rd, $time));
            end else begin
                check_value("wb_rd_o", wb_rd, exp_rd_q[0]);
                check_value("wb_data_o", wb_data, exp_data_q[0]);
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
                retired++;
            end
        end
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        instr       = 32'h0000_0013;  // ADDI x0, x0, 0
        instr_valid = 1'b0;
        mispredict  = 1'b0;
        stall_seen  = 1'b0;
        retired     = 0;
        void'($urandom(32'h2088_1105));
        for (int r = 0; r < 32; r++) begin
            arch_regs[r] = '0;
        end
        build_table();

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // Quiet outputs through the post-reset flush
        repeat (3) begin
            @(negedge clk);
            check_value("stall_o", stall, 32'd0);
            check_value("wb_valid_o", wb_valid, 32'd0);
        end
        @(posedge clk);

        // Second pass adds idle gaps, never right before a mispredict
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < tbl_instr.size(); i++) begin
                gap = 0;
                if (pass == 1 && !tbl_mispredict[i]) begin
                    gap = $urandom % 3;
                end
                repeat (gap) begin
                    instr_valid <= 1'b0;
                    mispredict  <= 1'b0;
                    @(posedge clk);
                end
                instr       <= tbl_instr[i];
                instr_valid <= 1'b1;
                mispredict  <= tbl_mispredict[i];
                if (tbl_mispredict[i]) begin
                    @(posedge clk);  // Dropped by the flush
                end else begin
                    wait_accept();
                end
                if (!tbl_squash[i]) begin
                    model_apply(tbl_instr[i]);
                end
            end
        end
        instr_valid <= 1'b0;
        mispredict  <= 1'b0;

        waited = 0;
        while (exp_rd_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        repeat (6) @(posedge clk);  // Room for a stray late writeback
        check_value("stall_o seen", stall_seen, 32'd1);

        if (exp_rd_q.size() != 0) begin
            abort_run($sformatf("%0d expected writebacks never appeared", exp_rd_q.size()));
        end else begin
            $display("%0d writebacks checked", retired);
            $display("Test passed");
            $finish;
        end
    end

endmodule
